//--- flist.f
fp_types.sv
fp_rnd_if.sv
fp_ext.sv
fp_cmp_max.sv
fp_cvt_i2f.sv
fp_rnd.sv
fp_csr.sv
fp_hub.sv
fp_unit.sv
fp_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the float32 unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f flist.f --top-module fp_unit_tb -o fp_unit_sim > build.log 2>&1 \
    && ./obj_dir/fp_unit_sim > sim.log 2>&1 \
    || echo "RESULT: FAIL" >> sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log and build.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- fp_unit_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench of the float32 execution unit.
//   Sign injection, moves, compares, min/max and classify
//   Integer conversion against a rounding model, all modes
//   Sticky flags, dynamic rounding mode and clear
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_unit_tb import fp_types::*; ();

    localparam fp_flags_t NO_FLAGS    = 5'b00000;
    localparam fp_flags_t NV_FLAG     = 5'b10000;
    localparam int        CVT_TIMEOUT = 100;

    logic        clock_i;
    logic        reset_i;
    logic        enable_i;
    fp_op_e      op_i;
    fp_rm_e      rm_i;
    logic [31:0] data1_i;
    logic [31:0] data2_i;
    logic        clear_i;
    logic        frm_we_i;
    fp_rm_e      frm_wdata_i;
    logic        fflags_clr_i;
    logic [31:0] result_o;
    fp_flags_t   flags_o;
    logic        ready_o;
    fp_rm_e      frm_o;
    fp_flags_t   fflags_o;

    int          checks;
    int          errors;
    int          test_errors;
    integer      seed;
    int          dyn_count;
    fp_flags_t   fflags_exp;
    fp_rm_e      modes [6] = '{RM_RNE, RM_RTZ, RM_RDN, RM_RUP, RM_RMM, RM_DYN};
    logic [31:0] class_vals [10] = '{
        32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
        32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000
    };
    logic [31:0] fixed_vals [10] = '{
        32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0007, 32'h00FF_FFFF,
        32'h0100_0001, 32'h7FFF_FFFF, 32'h8000_0000, 32'h1234_5678, 32'hFFFF_FFFB
    };

    fp_unit #(.SHIFT_STEP(4)) DUT (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .op_i         (op_i),
        .rm_i         (rm_i),
        .data1_i      (data1_i),
        .data2_i      (data2_i),
        .clear_i      (clear_i),
        .frm_we_i     (frm_we_i),
        .frm_wdata_i  (frm_wdata_i),
        .fflags_clr_i (fflags_clr_i),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .ready_o      (ready_o),
        .frm_o        (frm_o),
        .fflags_o     (fflags_o)
    );

    always #50 clock_i = ~clock_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flags(input string name, input fp_flags_t expected,
                               input fp_flags_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_rm(input string name, input fp_rm_e expected, input fp_rm_e actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of integer to float32 with rounding.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic model_convert(input logic [31:0] value, input logic uns,
                                 input fp_rm_e mode, output logic [31:0] res,
                                 output fp_flags_t flags);
        logic        neg;
        logic [31:0] mag;
        logic [32:0] kept;
        logic [31:0] rest;
        logic [31:0] half;
        logic        up;
        logic [7:0]  expo;
        int          msb;
        int          drop;
        neg   = !uns && value[31];
        mag   = neg ? (~value + 32'd1) : value;
        flags = NO_FLAGS;
        res   = '0;
        if (mag != 0) begin
            msb = 31;
            while (!mag[msb]) msb--;
            drop = (msb > 23) ? msb - 23 : 0;
            kept = (msb > 23) ? 33'(mag >> drop) : 33'(mag << (23 - msb));
            rest = (drop == 0) ? 32'd0 : mag & ((32'd1 << drop) - 32'd1);
            half = (drop == 0) ? 32'd0 : 32'd1 << (drop - 1);
            case (mode)
                RM_RTZ:  up = 1'b0;
                RM_RDN:  up = neg && rest != 0;
                RM_RUP:  up = !neg && rest != 0;
                RM_RMM:  up = rest != 0 && rest >= half;
                default: up = rest > half || (rest != 0 && rest == half && kept[0]);
            endcase
            kept = kept + 33'(up);
            expo = 8'(127 + msb);
            // Rounding carried into the next binade.
            if (kept[24]) begin
                expo = expo + 8'd1;
                kept = kept >> 1;
            end
            res      = {neg, expo, kept[22:0]};
            flags.nx = (rest != 0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers. All of them start and end 1 ns after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apply_simple(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] exp_res, input fp_flags_t exp_flags);
        enable_i = 1'b1;
        op_i     = op;
        rm_i     = RM_RNE;
        data1_i  = a;
        data2_i  = b;
        @(negedge clock_i);
        check_word("result_o", exp_res, result_o);
        check_flags("flags_o", exp_flags, flags_o);
        check_word("ready_o", 32'd1, 32'(ready_o));
        @(posedge clock_i);
        #1;
        enable_i = 1'b0;
        @(negedge clock_i);
        check_word("ready_o", 32'd0, 32'(ready_o));
        @(posedge clock_i);
        #1;
    endtask

    task automatic write_frm(input fp_rm_e mode);
        frm_we_i    = 1'b1;
        frm_wdata_i = mode;
        @(posedge clock_i);
        #1;
        frm_we_i = 1'b0;
        check_rm("frm_o", mode, frm_o);
    endtask

    task automatic clear_fflags();
        fflags_clr_i = 1'b1;
        @(posedge clock_i);
        #1;
        fflags_clr_i = 1'b0;
        fflags_exp   = NO_FLAGS;
        check_flags("fflags_o", NO_FLAGS, fflags_o);
    endtask

    task automatic convert(input logic [31:0] value, input logic uns, input fp_rm_e rm);
        fp_rm_e      mode;
        logic [31:0] exp_res;
        fp_flags_t   exp_flags;
        int          cycles;
        logic        seen;
        mode = rm;
        if (rm == RM_DYN) begin
            mode = modes[dyn_count % 5];
            dyn_count++;
            write_frm(mode);
        end
        model_convert(value, uns, mode, exp_res, exp_flags);
        enable_i = 1'b1;
        op_i     = uns ? OP_CVT_WU : OP_CVT_W;
        rm_i     = rm;
        data1_i  = value;
        data2_i  = '0;
        cycles   = 0;
        seen     = 1'b0;
        while (!seen && cycles < CVT_TIMEOUT) begin
            @(posedge clock_i);
            #1;
            cycles++;
            seen = ready_o;
        end
        if (!seen) begin
            $display("Conversion of %h did not finish within %0d cycles", value, CVT_TIMEOUT);
            errors++;
        end else begin
            if (cycles < 3) begin
                $display("Conversion of %h was ready after only %0d cycles", value, cycles);
                errors++;
            end
            check_word("result_o", exp_res, result_o);
            check_flags("flags_o", exp_flags, flags_o);
            fflags_exp = fflags_exp | exp_flags;
            // Hold the request over the edge that accepts the result.
            @(posedge clock_i);
            #1;
        end
        enable_i = 1'b0;
        @(negedge clock_i);
        check_word("ready_o", 32'd0, 32'(ready_o));
        check_flags("fflags_o", fflags_exp, fflags_o);
        @(posedge clock_i);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic sign_and_move();
        apply_simple(OP_SGNJ, 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, NO_FLAGS);
        apply_simple(OP_SGNJ, 32'hBF80_0000, 32'h4000_0000, 32'h3F80_0000, NO_FLAGS);
        apply_simple(OP_SGNJN, 32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, NO_FLAGS);
        apply_simple(OP_SGNJN, 32'h3F80_0000, 32'h4000_0000, 32'hBF80_0000, NO_FLAGS);
        apply_simple(OP_SGNJX, 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, NO_FLAGS);
        apply_simple(OP_SGNJX, 32'hBF80_0000, 32'h4000_0000, 32'hBF80_0000, NO_FLAGS);
        apply_simple(OP_MV_X2F, 32'h1234_5678, 32'h0, 32'h1234_5678, NO_FLAGS);
        apply_simple(OP_MV_F2X, 32'hDEAD_BEEF, 32'h0, 32'hDEAD_BEEF, NO_FLAGS);
        report_test("sign injection and moves");
    endtask

    task automatic compares();
        apply_simple(OP_EQ, 32'h3F80_0000, 32'h3F80_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_EQ, 32'h3F80_0000, 32'h4000_0000, 32'd0, NO_FLAGS);
        apply_simple(OP_EQ, 32'h0000_0000, 32'h8000_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_EQ, 32'h7FC0_0000, 32'h3F80_0000, 32'd0, NO_FLAGS);
        apply_simple(OP_EQ, 32'h7F80_0001, 32'h3F80_0000, 32'd0, NV_FLAG);
        apply_simple(OP_LT, 32'h3F80_0000, 32'h4000_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_LT, 32'h4000_0000, 32'h3F80_0000, 32'd0, NO_FLAGS);
        apply_simple(OP_LT, 32'hBF80_0000, 32'h3F80_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_LT, 32'hC000_0000, 32'hBF80_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_LT, 32'h8000_0000, 32'h0000_0000, 32'd0, NO_FLAGS);
        apply_simple(OP_LT, 32'h7FC0_0000, 32'h3F80_0000, 32'd0, NV_FLAG);
        apply_simple(OP_LE, 32'h3F80_0000, 32'h3F80_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_LE, 32'h4000_0000, 32'h3F80_0000, 32'd0, NO_FLAGS);
        apply_simple(OP_LE, 32'h8000_0000, 32'h0000_0000, 32'd1, NO_FLAGS);
        apply_simple(OP_LE, 32'h3F80_0000, 32'h7F80_0001, 32'd0, NV_FLAG);
        report_test("compare");
    endtask

    task automatic min_max();
        apply_simple(OP_MIN, 32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, NO_FLAGS);
        apply_simple(OP_MAX, 32'h3F80_0000, 32'h4000_0000, 32'h4000_0000, NO_FLAGS);
        apply_simple(OP_MIN, 32'hBF80_0000, 32'hC000_0000, 32'hC000_0000, NO_FLAGS);
        apply_simple(OP_MIN, 32'h7FC0_0000, 32'h4000_0000, 32'h4000_0000, NO_FLAGS);
        apply_simple(OP_MAX, 32'h3F80_0000, 32'h7FC0_0000, 32'h3F80_0000, NO_FLAGS);
        apply_simple(OP_MIN, 32'h7FC0_0000, 32'h7FC0_0001, CANON_NAN, NO_FLAGS);
        apply_simple(OP_MAX, 32'h7F80_0001, 32'hFF80_0002, CANON_NAN, NV_FLAG);
        apply_simple(OP_MIN, 32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, NV_FLAG);
        apply_simple(OP_MIN, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, NO_FLAGS);
        apply_simple(OP_MAX, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, NO_FLAGS);
        report_test("min and max");
    endtask

    task automatic classify();
        for (int k = 0; k < 10; k++) begin
            apply_simple(OP_CLASS, class_vals[k], 32'h0, 32'd1 << k, NO_FLAGS);
        end
        report_test("classify");
    endtask

    task automatic conversions();
        logic [31:0] value;
        check_rm("frm_o", RM_RNE, frm_o);
        clear_fflags();
        for (int k = 0; k < 10; k++) begin
            for (int m = 0; m < 6; m++) begin
                convert(fixed_vals[k], 1'b0, modes[m]);
                convert(fixed_vals[k], 1'b1, modes[m]);
            end
        end
        for (int n = 0; n < 50; n++) begin
            value = $random(seed);
            for (int m = 0; m < 6; m++) begin
                convert(value, (n % 2) == 1, modes[m]);
            end
        end
        clear_fflags();
        report_test("conversion");
    endtask

    task automatic clear_abort();
        int   cycles;
        logic seen;
        // Only nv is sticky here. A stray accumulate of nx would show.
        clear_fflags();
        apply_simple(OP_EQ, 32'h7F80_0001, 32'h3F80_0000, 32'd0, NV_FLAG);
        fflags_exp = NV_FLAG;
        enable_i   = 1'b1;
        op_i       = OP_CVT_W;
        rm_i       = RM_RNE;
        data1_i    = 32'h0100_0001;
        data2_i    = '0;
        cycles     = 0;
        seen       = 1'b0;
        while (!seen && cycles < CVT_TIMEOUT) begin
            @(posedge clock_i);
            #1;
            cycles++;
            seen = ready_o;
        end
        if (!seen) begin
            $display("Conversion before the clear did not finish within %0d cycles",
                     CVT_TIMEOUT);
            errors++;
        end
        // The clear lands in the cycle that shows the inexact result.
        clear_i = 1'b1;
        @(negedge clock_i);
        check_word("result_o", 32'd0, result_o);
        check_flags("flags_o", NO_FLAGS, flags_o);
        check_word("ready_o", 32'd0, 32'(ready_o));
        @(posedge clock_i);
        #1;
        clear_i  = 1'b0;
        enable_i = 1'b0;
        @(negedge clock_i);
        check_flags("fflags_o", fflags_exp, fflags_o);
        check_word("ready_o", 32'd0, 32'(ready_o));
        @(posedge clock_i);
        #1;
        convert(32'h0000_0001, 1'b1, RM_RNE);
        convert(32'hFFFF_FFFB, 1'b0, RM_RTZ);
        report_test("clear");
    endtask

    initial begin
        clock_i      = 1'b0;
        reset_i      = 1'b1;
        enable_i     = 1'b0;
        op_i         = OP_SGNJ;
        rm_i         = RM_RNE;
        data1_i      = '0;
        data2_i      = '0;
        clear_i      = 1'b0;
        frm_we_i     = 1'b0;
        frm_wdata_i  = RM_RNE;
        fflags_clr_i = 1'b0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        seed         = 97;
        dyn_count    = 0;
        fflags_exp   = NO_FLAGS;

        repeat (3) @(posedge clock_i);
        #1;
        reset_i = 1'b0;
        @(posedge clock_i);
        #1;

        sign_and_move();
        compares();
        min_max();
        classify();
        conversions();
        clear_abort();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- fp_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Float32 execution unit, top level.
// Hub, two classifiers, compare and min/max, integer conversion
// with its rounder, and the control registers.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_unit import fp_types::*; #(
    parameter int unsigned SHIFT_STEP = 4
) (
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  fp_op_e      op_i,
    input  fp_rm_e      rm_i,
    input  logic [31:0] data1_i,
    input  logic [31:0] data2_i,
    input  logic        clear_i,
    input  logic        frm_we_i,
    input  fp_rm_e      frm_wdata_i,
    input  logic        fflags_clr_i,
    output logic [31:0] result_o,
    output fp_flags_t   flags_o,
    output logic        ready_o,
    output fp_rm_e      frm_o,
    output fp_flags_t   fflags_o
);

    logic [31:0] data1_g;
    logic [31:0] data2_g;
    fp_ext_t     ext1;
    fp_ext_t     ext2;
    logic [31:0] cmp_result;
    fp_flags_t   cmp_flags;
    logic        cvt_valid;
    logic        cvt_unsigned;
    fp_rm_e      cvt_rm;
    logic        accept;

    fp_rnd_if rnd_bus ();

    fp_hub u_hub (
        .enable_i       (enable_i),
        .op_i           (op_i),
        .rm_i           (rm_i),
        .data1_i        (data1_i),
        .data2_i        (data2_i),
        .clear_i        (clear_i),
        .frm_i          (frm_o),
        .ext1_i         (ext1),
        .ext2_i         (ext2),
        .cmp_result_i   (cmp_result),
        .cmp_flags_i    (cmp_flags),
        .data1_o        (data1_g),
        .data2_o        (data2_g),
        .cvt_valid_o    (cvt_valid),
        .cvt_unsigned_o (cvt_unsigned),
        .cvt_rm_o       (cvt_rm),
        .rnd            (rnd_bus.hub),
        .result_o       (result_o),
        .flags_o        (flags_o),
        .ready_o        (ready_o),
        .accept_o       (accept)
    );

    fp_ext u_ext1 (.data_i(data1_g), .ext_o(ext1));
    fp_ext u_ext2 (.data_i(data2_g), .ext_o(ext2));

    fp_cmp_max u_cmp_max (
        .op_i     (op_i),
        .data1_i  (data1_g),
        .data2_i  (data2_g),
        .ext1_i   (ext1),
        .ext2_i   (ext2),
        .result_o (cmp_result),
        .flags_o  (cmp_flags)
    );

    fp_cvt_i2f #(.SHIFT_STEP(SHIFT_STEP)) u_cvt_i2f (
        .clock_i    (clock_i),
        .reset_i    (reset_i),
        .clear_i    (clear_i),
        .valid_i    (cvt_valid),
        .unsigned_i (cvt_unsigned),
        .data_i     (data1_g),
        .rm_i       (cvt_rm),
        .rnd        (rnd_bus.cvt)
    );

    fp_rnd u_rnd (
        .clock_i (clock_i),
        .reset_i (reset_i),
        .clear_i (clear_i),
        .rnd     (rnd_bus.rnd)
    );

    fp_csr u_csr (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .frm_we_i     (frm_we_i),
        .frm_wdata_i  (frm_wdata_i),
        .fflags_clr_i (fflags_clr_i),
        .accept_i     (accept),
        .flags_i      (flags_o),
        .frm_o        (frm_o),
        .fflags_o     (fflags_o)
    );

endmodule

//--- fp_hub.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch hub of the float32 unit.
// Gates operands, resolves the rounding mode, starts conversions
// and picks the result and flags that leave the unit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_hub import fp_types::*; (
    input  logic        enable_i,
    input  fp_op_e      op_i,
    input  fp_rm_e      rm_i,
    input  logic [31:0] data1_i,
    input  logic [31:0] data2_i,
    input  logic        clear_i,
    input  fp_rm_e      frm_i,
    input  fp_ext_t     ext1_i,
    input  fp_ext_t     ext2_i,
    input  logic [31:0] cmp_result_i,
    input  fp_flags_t   cmp_flags_i,
    output logic [31:0] data1_o,
    output logic [31:0] data2_o,
    output logic        cvt_valid_o,
    output logic        cvt_unsigned_o,
    output fp_rm_e      cvt_rm_o,
    fp_rnd_if.hub       rnd,
    output logic [31:0] result_o,
    output fp_flags_t   flags_o,
    output logic        ready_o,
    output logic        accept_o
);

    logic is_cvt;

    assign data1_o = enable_i ? data1_i : '0;
    assign data2_o = enable_i ? data2_i : '0;

    assign is_cvt         = (op_i == OP_CVT_W) || (op_i == OP_CVT_WU);
    assign cvt_valid_o    = enable_i & is_cvt;
    assign cvt_unsigned_o = (op_i == OP_CVT_WU);
    assign cvt_rm_o       = (rm_i == RM_DYN) ? frm_i : rm_i;

    always_comb begin
        result_o = '0;
        flags_o  = '0;
        ready_o  = enable_i;

        if (enable_i) begin
            case (op_i)
                OP_SGNJ:  result_o = {ext2_i.sign, data1_o[30:0]};
                OP_SGNJN: result_o = {~ext2_i.sign, data1_o[30:0]};
                OP_SGNJX: result_o = {ext1_i.sign ^ ext2_i.sign, data1_o[30:0]};
                OP_MIN, OP_MAX, OP_EQ, OP_LT, OP_LE: begin
                    result_o = cmp_result_i;
                    flags_o  = cmp_flags_i;
                end
                OP_CLASS: result_o = {22'd0, ext1_i.classification};
                OP_MV_X2F, OP_MV_F2X: result_o = data1_o;
                OP_CVT_W, OP_CVT_WU: begin
                    // Held low until the rounder pulses.
                    ready_o = rnd.ready;
                    if (rnd.ready) begin
                        result_o = rnd.result;
                        flags_o  = rnd.flags;
                    end
                end
                default: ;
            endcase
        end

        if (clear_i) begin
            result_o = '0;
            flags_o  = '0;
            ready_o  = 1'b0;
        end
    end

    assign accept_o = ready_o & enable_i;

endmodule

//--- fp_csr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control registers: dynamic rounding mode and sticky flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_csr import fp_types::*; (
    input  logic      clock_i,
    input  logic      reset_i,
    input  logic      frm_we_i,
    input  fp_rm_e    frm_wdata_i,
    input  logic      fflags_clr_i,
    input  logic      accept_i,
    input  fp_flags_t flags_i,
    output fp_rm_e    frm_o,
    output fp_flags_t fflags_o
);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            frm_o <= FRM_RESET;
        end else if (frm_we_i) begin
            frm_o <= frm_wdata_i;
        end
    end

    // Clear wins over the accumulate.
    always_ff @(posedge clock_i) begin
        if (reset_i || fflags_clr_i) begin
            fflags_o <= FLAGS_RESET;
        end else if (accept_i) begin
            fflags_o <= fflags_o | flags_i;
        end
    end

endmodule

//--- fp_rnd.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Float32 rounder.
// Rounds a left-aligned 32-bit mantissa to 24 bits, registered.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_rnd import fp_types::*; (
    input  logic  clock_i,
    input  logic  reset_i,
    input  logic  clear_i,
    fp_rnd_if.rnd rnd
);

    logic [23:0] keep;
    logic        guard;
    logic        sticky;
    logic        inexact;
    logic        round_up;
    logic [24:0] sum;
    logic [7:0]  exp_d;
    fp_flags_t   flags_d;

    logic        ready_q;
    logic [31:0] result_q;
    fp_flags_t   flags_q;

    assign keep    = rnd.mantissa[31:8];
    assign guard   = rnd.mantissa[7];
    assign sticky  = |rnd.mantissa[6:0];
    assign inexact = guard | sticky;

    always_comb begin
        case (rnd.rm)
            RM_RTZ:  round_up = 1'b0;
            RM_RDN:  round_up = inexact & rnd.sign;
            RM_RUP:  round_up = inexact & ~rnd.sign;
            RM_RMM:  round_up = guard;
            default: round_up = guard & (sticky | keep[0]);
        endcase
    end

    // Carry out of the mantissa moves up one binade.
    assign sum   = {1'b0, keep} + 25'(round_up);
    assign exp_d = sum[24] ? rnd.exponent + 8'd1 : rnd.exponent;

    always_comb begin
        flags_d    = '0;
        flags_d.nx = inexact;
    end

    always_ff @(posedge clock_i) begin
        if (reset_i || clear_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= rnd.valid;
        end
    end

    always_ff @(posedge clock_i) begin
        if (rnd.valid) begin
            result_q <= {rnd.sign, exp_d, sum[22:0]};
            flags_q  <= flags_d;
        end
    end

    assign rnd.ready  = ready_q;
    assign rnd.result = result_q;
    assign rnd.flags  = flags_q;

endmodule

//--- fp_cvt_i2f.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer to float32 normalizer.
// Shifts the magnitude left until bit 31 is set, then hands the
// sign, biased exponent and aligned mantissa to the rounder.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_cvt_i2f import fp_types::*; #(
    parameter int unsigned SHIFT_STEP = 4
) (
    input  logic        clock_i,
    input  logic        reset_i,
    input  logic        clear_i,
    input  logic        valid_i,
    input  logic        unsigned_i,
    input  logic [31:0] data_i,
    input  fp_rm_e      rm_i,
    fp_rnd_if.cvt       rnd
);

    typedef enum logic [1:0] {ST_IDLE, ST_NORM, ST_DONE} state_e;

    state_e      state_q;
    logic        valid_q;
    logic        sign_q;
    logic [7:0]  exp_q;
    logic [31:0] mant_q;
    fp_rm_e      rm_q;
    logic        neg;

    assign neg = ~unsigned_i & data_i[31];

    // Control state.
    always_ff @(posedge clock_i) begin
        if (reset_i || clear_i) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: if (valid_i) state_q <= ST_NORM;
                ST_NORM: begin
                    if (mant_q == '0 || mant_q[31]) begin
                        valid_q <= 1'b1;
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: if (!valid_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Datapath, 158 is the bias plus 31.
    always_ff @(posedge clock_i) begin
        if (state_q == ST_IDLE && valid_i) begin
            sign_q <= neg;
            rm_q   <= rm_i;
            mant_q <= neg ? -data_i : data_i;
            exp_q  <= (data_i == '0) ? 8'd0 : 8'd158;
        end else if (state_q == ST_NORM && mant_q != '0 && !mant_q[31]) begin
            if (mant_q[31 -: SHIFT_STEP] == '0) begin
                mant_q <= mant_q << SHIFT_STEP;
                exp_q  <= exp_q - 8'(SHIFT_STEP);
            end else begin
                mant_q <= mant_q << 1;
                exp_q  <= exp_q - 8'd1;
            end
        end
    end

    assign rnd.valid    = valid_q;
    assign rnd.sign     = sign_q;
    assign rnd.exponent = exp_q;
    assign rnd.mantissa = mant_q;
    assign rnd.rm       = rm_q;

endmodule

//--- fp_cmp_max.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Float32 compare (EQ, LT, LE) and MIN/MAX.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_cmp_max import fp_types::*; (
    input  fp_op_e      op_i,
    input  logic [31:0] data1_i,
    input  logic [31:0] data2_i,
    input  fp_ext_t     ext1_i,
    input  fp_ext_t     ext2_i,
    output logic [31:0] result_o,
    output fp_flags_t   flags_o
);

    logic [30:0] mag1;
    logic [30:0] mag2;
    logic        any_nan;
    logic        both_nan;
    logic        any_snan;
    logic        both_zero;
    logic        lt_total;
    logic        lt;
    logic        eq;

    assign mag1      = {ext1_i.exponent, ext1_i.mantissa[22:0]};
    assign mag2      = {ext2_i.exponent, ext2_i.mantissa[22:0]};
    assign any_nan   = ext1_i.is_nan | ext2_i.is_nan;
    assign both_nan  = ext1_i.is_nan & ext2_i.is_nan;
    assign any_snan  = ext1_i.is_snan | ext2_i.is_snan;
    assign both_zero = (ext1_i.classification[3] | ext1_i.classification[4]) &
                       (ext2_i.classification[3] | ext2_i.classification[4]);

    // Total order on non-NaN values, -0 sits below +0.
    always_comb begin
        if (ext1_i.sign != ext2_i.sign) begin
            lt_total = ext1_i.sign;
        end else if (ext1_i.sign) begin
            lt_total = (mag1 > mag2);
        end else begin
            lt_total = (mag1 < mag2);
        end
    end

    // Compares see both zeros as equal.
    assign lt = lt_total & ~both_zero;
    assign eq = (data1_i == data2_i) | both_zero;

    always_comb begin
        result_o = '0;
        flags_o  = '0;
        case (op_i)
            OP_EQ: begin
                result_o = {31'd0, eq & ~any_nan};
                flags_o.nv = any_snan;
            end
            OP_LT: begin
                result_o = {31'd0, lt & ~any_nan};
                flags_o.nv = any_nan;
            end
            OP_LE: begin
                result_o = {31'd0, (lt | eq) & ~any_nan};
                flags_o.nv = any_nan;
            end
            OP_MIN, OP_MAX: begin
                flags_o.nv = any_snan;
                if (both_nan) begin
                    result_o = CANON_NAN;
                end else if (ext1_i.is_nan) begin
                    result_o = data2_i;
                end else if (ext2_i.is_nan) begin
                    result_o = data1_i;
                end else if ((op_i == OP_MIN) == lt_total) begin
                    result_o = data1_i;
                end else begin
                    result_o = data2_i;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- fp_ext.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Float32 operand classifier.
// Splits the fields, restores the hidden bit and builds the class mask.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fp_ext import fp_types::*; (
    input  logic [31:0] data_i,
    output fp_ext_t     ext_o
);

    logic        sign;
    logic [7:0]  exp_f;
    logic [22:0] frac_f;
    logic        exp_zero;
    logic        exp_ones;
    logic        frac_zero;

    assign sign      = data_i[31];
    assign exp_f     = data_i[30:23];
    assign frac_f    = data_i[22:0];
    assign exp_zero  = (exp_f == 8'h00);
    assign exp_ones  = (exp_f == 8'hFF);
    assign frac_zero = (frac_f == '0);

    always_comb begin
        ext_o.sign     = sign;
        ext_o.exponent = exp_f;
        ext_o.mantissa = {~exp_zero, frac_f};
        ext_o.is_nan   = exp_ones & ~frac_zero;
        // Signaling when the top fraction bit is clear.
        ext_o.is_snan  = exp_ones & ~frac_zero & ~frac_f[22];

        ext_o.classification[0] = sign & exp_ones & frac_zero;
        ext_o.classification[1] = sign & ~exp_zero & ~exp_ones;
        ext_o.classification[2] = sign & exp_zero & ~frac_zero;
        ext_o.classification[3] = sign & exp_zero & frac_zero;
        ext_o.classification[4] = ~sign & exp_zero & frac_zero;
        ext_o.classification[5] = ~sign & exp_zero & ~frac_zero;
        ext_o.classification[6] = ~sign & ~exp_zero & ~exp_ones;
        ext_o.classification[7] = ~sign & exp_ones & frac_zero;
        ext_o.classification[8] = exp_ones & ~frac_zero & ~frac_f[22];
        ext_o.classification[9] = exp_ones & frac_f[22];
    end

endmodule

//--- fp_rnd_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rounder interface.
// Normalized value from the converter, rounded result to the hub.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface fp_rnd_if import fp_types::*; ();

    logic        valid;
    logic        sign;
    logic [7:0]  exponent;
    logic [31:0] mantissa;
    fp_rm_e      rm;

    logic        ready;
    logic [31:0] result;
    fp_flags_t   flags;

    modport cvt (output valid, sign, exponent, mantissa, rm);
    modport rnd (input valid, sign, exponent, mantissa, rm, output ready, result, flags);
    modport hub (input ready, result, flags);

endinterface

//--- fp_types.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the float32 execution unit.
//   fp_op_e      opcode set of the unit
//   fp_rm_e      rounding mode encodings
//   fp_flags_t   exception flags
//   fp_class_t   one-hot class mask
//   fp_ext_t     classified and split operand
// Also the canonical NaN and the register reset values.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fp_types;

    typedef enum logic [3:0] {
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MIN,
        OP_MAX,
        OP_EQ,
        OP_LT,
        OP_LE,
        OP_CLASS,
        OP_MV_X2F,
        OP_MV_F2X,
        OP_CVT_W,
        OP_CVT_WU
    } fp_op_e;

    // Codes 5 and 6 are not named and fall back to RNE.
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4,
        RM_DYN = 3'd7
    } fp_rm_e;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fp_flags_t;

    // Bit 0 is negative infinity, bit 9 is quiet NaN.
    typedef logic [9:0] fp_class_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [23:0] mantissa;
        fp_class_t   classification;
        logic        is_nan;
        logic        is_snan;
    } fp_ext_t;

    localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

    localparam fp_rm_e    FRM_RESET   = RM_RNE;
    localparam fp_flags_t FLAGS_RESET = '0;

endpackage
